// File: dv/alu_exec_tb.sv
`timescale 1ns/1ps

module alu_exec_tb;
  import ooo_pkg::*;

  localparam int wait_limit = 200;

  logic                       clk;
  logic                       rst_n;
  logic                       flush;
  logic                       issue;
  issue_pkt_t                 issue_pkt;
  cdb_pkt_t [CDB_LANES-2:0]   cdb_ext;
  logic                       alu_rs_full;
  cdb_pkt_t                   cdb_out;

  integer seed = 32'h5753_ed14;
  int     errors = 0;
  int     checks = 0;
  int     pending = 0;

  // scoreboard indexed by rob tag
  logic   exp_valid [1 << ROB_TAG_W];
  word_t  exp_val   [1 << ROB_TAG_W];
  int     next_tag = 0;

  alu_exec_top alu_exec_top_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush       (flush),
    .issue       (issue),
    .issue_pkt   (issue_pkt),
    .cdb_ext     (cdb_ext),
    .alu_rs_full (alu_rs_full),
    .cdb_out     (cdb_out)
  );

  always #5 clk = ~clk;

  // reference model from the isa rules
  function automatic word_t src_value(input operand_src_t s);
    if (s.regfile_ready) begin
      return s.regfile_v;
    end
    return s.rob_v;
  endfunction

  function automatic word_t model(input issue_pkt_t p);
    word_t a;
    word_t b;
    a = src_value(p.rs1);
    b = (p.opcode == reg_opcode) ? src_value(p.rs2) : p.imm;
    if (p.opcode == lui_opcode) begin
      return p.imm;
    end
    if (p.opcode == auipc_opcode) begin
      return p.pc + p.imm;
    end
    case (p.funct3)
      3'b000:  return (p.opcode == reg_opcode && p.funct7[5]) ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return {31'b0, $signed(a) < $signed(b)};
      3'b011:  return {31'b0, a < b};
      3'b100:  return a ^ b;
      3'b101:  return p.funct7[5] ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic operand_src_t ready_src(input word_t v);
    operand_src_t s;
    s.regfile_ready = 1'b1;
    s.regfile_v     = v;
    s.rob           = '0;
    s.rob_ready     = 1'b0;
    s.rob_v         = $random(seed);
    return s;
  endfunction

  function automatic operand_src_t wait_src(input rob_tag_t tag);
    operand_src_t s;
    s           = '0;
    s.rob       = tag;
    s.regfile_v = $random(seed);
    return s;
  endfunction

  // operands waiting on tag take v as the cdb would deliver it
  function automatic issue_pkt_t resolve(input issue_pkt_t p, input rob_tag_t tag,
                                         input word_t v);
    issue_pkt_t r;
    r = p;
    if (!p.rs1.regfile_ready && !p.rs1.rob_ready && p.rs1.rob == tag) begin
      r.rs1 = ready_src(v);
    end
    if (!p.rs2.regfile_ready && !p.rs2.rob_ready && p.rs2.rob == tag) begin
      r.rs2 = ready_src(v);
    end
    return r;
  endfunction

  function automatic issue_pkt_t make_pkt(input opcode_t op, input funct3_t f3,
                                          input funct7_t f7, input rob_tag_t tag);
    issue_pkt_t p;
    p.opcode     = op;
    p.funct3     = f3;
    p.funct7     = f7;
    p.imm        = $random(seed);
    p.pc         = $random(seed);
    p.target_rob = tag;
    p.rs1        = ready_src($random(seed));
    p.rs2        = ready_src($random(seed));
    return p;
  endfunction

  // results may come back in any order
  always @(negedge clk) begin
    if (rst_n && cdb_out.valid) begin
      checks++;
      assert (exp_valid[cdb_out.rob]) else begin
        errors++;
        $display("unexpected result on cdb_out for rob tag %0d", cdb_out.rob);
      end
      if (exp_valid[cdb_out.rob]) begin
        checks++;
        assert (cdb_out.value == exp_val[cdb_out.rob]) else begin
          errors++;
          $display("Error: cdb_out.value tag %h got %h expected %h",
                   cdb_out.rob, cdb_out.value, exp_val[cdb_out.rob]);
        end
        exp_valid[cdb_out.rob] = 1'b0;
        pending--;
      end
    end
  end

  task automatic set_expect(input rob_tag_t tag, input word_t v);
    exp_valid[tag] = 1'b1;
    exp_val[tag]   = v;
    pending++;
  endtask

  task automatic drive_issue(input issue_pkt_t p);
    int cnt;
    cnt = 0;
    @(negedge clk);
    while (alu_rs_full && cnt < wait_limit) begin
      @(negedge clk);
      cnt++;
    end
    checks++;
    assert (!alu_rs_full) else begin
      errors++;
      $display("station stayed full, issue for rob tag %0d not sent", p.target_rob);
    end
    @(posedge clk);
    issue     <= 1'b1;
    issue_pkt <= p;
    @(posedge clk);
    issue     <= 1'b0;
  endtask

  task automatic wait_drain();
    int cnt;
    cnt = 0;
    while (pending != 0 && cnt < wait_limit) begin
      @(posedge clk);
      cnt++;
    end
    checks++;
    assert (pending == 0) else begin
      errors++;
      $display("timeout with %0d results still missing", pending);
      for (int i = 0; i < (1 << ROB_TAG_W); i++) begin
        exp_valid[i] = 1'b0;
      end
      pending = 0;
    end
  endtask

  task automatic check_full(input logic exp);
    @(negedge clk);
    checks++;
    assert (alu_rs_full == exp) else begin
      errors++;
      $display("Error: alu_rs_full got %h expected %h", alu_rs_full, exp);
    end
  endtask

  task automatic pulse_ext(input int lane, input rob_tag_t tag, input word_t v);
    cdb_pkt_t c;
    c.valid = 1'b1;
    c.rob   = tag;
    c.value = v;
    @(posedge clk);
    cdb_ext[lane] <= c;
    @(posedge clk);
    cdb_ext[lane].valid <= 1'b0;
  endtask

  task automatic run_ready(input opcode_t op, input funct3_t f3, input funct7_t f7);
    issue_pkt_t p;
    rob_tag_t   tag;
    tag = rob_tag_t'(next_tag);
    if (exp_valid[tag]) begin
      wait_drain();
    end
    next_tag = (next_tag + 1) % (1 << ROB_TAG_W);
    p = make_pkt(op, f3, f7, tag);
    set_expect(tag, model(p));
    drive_issue(p);
  endtask

  task automatic report(input string name, input int err0);
    $display("%-14s %0d errors", name, errors - err0);
  endtask

  task automatic ready_ops_test();
    int err0;
    err0 = errors;
    for (int f = 0; f < 8; f++) begin
      run_ready(reg_opcode, funct3_t'(f), 7'h00);
      run_ready(imm_opcode, funct3_t'(f), 7'h00);
    end
    // sub, sra and srai
    run_ready(reg_opcode, add_funct3, 7'h20);
    run_ready(reg_opcode, sr_funct3, 7'h20);
    run_ready(imm_opcode, sr_funct3, 7'h20);
    run_ready(lui_opcode, 3'b000, 7'h00);
    run_ready(auipc_opcode, 3'b000, 7'h00);
    wait_drain();
    report("ready_ops", err0);
  endtask

  task automatic priority_test();
    issue_pkt_t p;
    int         err0;
    err0 = errors;
    p = make_pkt(reg_opcode, add_funct3, 7'h00, 3'd1);
    p.rs1.rob_ready = 1'b1;
    p.rs2.regfile_ready = 1'b0;
    p.rs2.rob_ready = 1'b1;
    set_expect(3'd1, model(p));
    drive_issue(p);
    p = make_pkt(reg_opcode, 3'b100, 7'h00, 3'd2);
    p.rs1.regfile_ready = 1'b0;
    p.rs1.rob_ready = 1'b1;
    p.rs2.rob_ready = 1'b1;
    set_expect(3'd2, model(p));
    drive_issue(p);
    wait_drain();
    report("priority", err0);
  endtask

  task automatic ext_wakeup_test();
    issue_pkt_t p;
    word_t      v;
    int         err0;
    err0 = errors;
    p = make_pkt(reg_opcode, add_funct3, 7'h20, 3'd1);
    p.rs2 = wait_src(3'd6);
    drive_issue(p);
    // monitor flags anything for tag 1 in this window
    repeat (6) @(posedge clk);
    v = $random(seed);
    pulse_ext(1, 3'd6, v);
    set_expect(3'd1, model(resolve(p, 3'd6, v)));
    wait_drain();
    report("ext_wakeup", err0);
  endtask

  task automatic chain_test();
    issue_pkt_t a;
    issue_pkt_t b;
    int         err0;
    err0 = errors;
    a = make_pkt(imm_opcode, add_funct3, 7'h00, 3'd2);
    b = make_pkt(reg_opcode, 3'b100, 7'h00, 3'd3);
    b.rs1 = wait_src(3'd2);
    set_expect(3'd2, model(a));
    set_expect(3'd3, model(resolve(b, 3'd2, model(a))));
    drive_issue(a);
    drive_issue(b);
    wait_drain();
    report("chain", err0);
  endtask

  task automatic full_drain_test();
    issue_pkt_t held [RS_ENTRIES];
    word_t      v;
    int         err0;
    err0 = errors;
    for (int i = 0; i < RS_ENTRIES; i++) begin
      held[i] = make_pkt(reg_opcode, funct3_t'(i), 7'h00, rob_tag_t'(i));
      held[i].rs1 = wait_src(3'd0);
      drive_issue(held[i]);
      check_full(i == RS_ENTRIES - 1);
    end
    v = $random(seed);
    pulse_ext(0, 3'd0, v);
    for (int i = 0; i < RS_ENTRIES; i++) begin
      set_expect(rob_tag_t'(i), model(resolve(held[i], 3'd0, v)));
    end
    wait_drain();
    check_full(1'b0);
    report("full_drain", err0);
  endtask

  task automatic flush_test();
    issue_pkt_t p;
    int         err0;
    err0 = errors;
    // fill the station so the flush shows on alu_rs_full
    for (int i = 0; i < RS_ENTRIES; i++) begin
      p = make_pkt(reg_opcode, add_funct3, 7'h00, rob_tag_t'(i));
      p.rs1 = wait_src(3'd5);
      drive_issue(p);
    end
    check_full(1'b1);
    @(posedge clk);
    flush <= 1'b1;
    @(posedge clk);
    flush <= 1'b0;
    check_full(1'b0);
    pulse_ext(1, 3'd5, $random(seed));
    repeat (8) @(posedge clk);
    check_full(1'b0);
    // station still works after the flush
    run_ready(reg_opcode, 3'b111, 7'h00);
    wait_drain();
    report("flush", err0);
  endtask

  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    flush     = 1'b0;
    issue     = 1'b0;
    issue_pkt = '0;
    cdb_ext   = '0;
    for (int i = 0; i < (1 << ROB_TAG_W); i++) begin
      exp_valid[i] = 1'b0;
      exp_val[i]   = '0;
    end
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    ready_ops_test();
    priority_test();
    ext_wakeup_test();
    chain_test();
    full_drain_test();
    flush_test();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: list.f
src/ooo_pkg.sv
src/alu.sv
src/cmp.sv
src/alu_op_decode.sv
src/alu_rs.sv
src/alu_exec_top.sv
dv/alu_exec_tb.sv

// File: run.sh
#!/bin/sh
# build and run the alu execution slice testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  -f list.f \
  --top-module alu_exec_tb \
  -o alu_exec_sim

./obj_dir/alu_exec_sim > sim.log
cat sim.log

if grep -q "test failed" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
echo "simulation finished clean"

// File: src/alu.sv
`timescale 1ns/1ps

module alu (
  input  ooo_pkg::alu_op_e alu_op,
  input  ooo_pkg::word_t   a,
  input  ooo_pkg::word_t   b,
  output ooo_pkg::word_t   f
);
  import ooo_pkg::*;

  logic [4:0] shamt;

  // only the low five bits shift
  assign shamt = b[4:0];

  always_comb begin
    unique case (alu_op)
      add_alu_op: f = a + b;
      sub_alu_op: f = a - b;
      xor_alu_op: f = a ^ b;
      or_alu_op:  f = a | b;
      and_alu_op: f = a & b;
      sll_alu_op: f = a << shamt;
      srl_alu_op: f = a >> shamt;
      // arithmetic shift keeps the sign
      sra_alu_op: f = word_t'($signed(a) >>> shamt);
    endcase
  end

endmodule

// File: src/alu_exec_top.sv
`timescale 1ns/1ps

module alu_exec_top (
  input  logic                                       clk,
  input  logic                                       rst_n,
  input  logic                                       flush,
  input  logic                                       issue,
  input  ooo_pkg::issue_pkt_t                        issue_pkt,
  input  ooo_pkg::cdb_pkt_t [ooo_pkg::CDB_LANES-2:0] cdb_ext,
  output logic                                       alu_rs_full,
  output ooo_pkg::cdb_pkt_t                          cdb_out
);
  import ooo_pkg::*;

  // full bus seen by the station
  cdb_pkt_t [CDB_LANES-1:0] cdb;

  // own result sits in lane 0 so local dependents wake up
  assign cdb = {cdb_ext, cdb_out};

  alu_rs alu_rs_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush       (flush),
    .issue       (issue),
    .issue_pkt   (issue_pkt),
    .cdb         (cdb),
    .alu_rs_full (alu_rs_full),
    .cdb_out     (cdb_out)
  );

endmodule

// File: src/alu_op_decode.sv
`timescale 1ns/1ps

module alu_op_decode (
  input  ooo_pkg::opcode_t opcode,
  input  ooo_pkg::funct3_t funct3,
  input  ooo_pkg::funct7_t funct7,
  output logic             use_cmp,
  output ooo_pkg::alu_op_e alu_op,
  output ooo_pkg::cmp_op_e cmp_op
);
  import ooo_pkg::*;

  always_comb begin
    use_cmp = 1'b0;
    alu_op  = add_alu_op;
    cmp_op  = blt_cmp_op;
    case (opcode)
      // operands already hold 0 or pc plus the immediate
      lui_opcode, auipc_opcode: begin
        alu_op = add_alu_op;
      end
      imm_opcode, reg_opcode: begin
        case (funct3)
          slt_funct3: begin
            use_cmp = 1'b1;
            cmp_op  = blt_cmp_op;
          end
          sltu_funct3: begin
            use_cmp = 1'b1;
            cmp_op  = bltu_cmp_op;
          end
          sr_funct3: begin
            alu_op = funct7[5] ? sra_alu_op : srl_alu_op;
          end
          add_funct3: begin
            // addi has no sub form since its upper bits are immediate
            if (opcode == reg_opcode && funct7[5]) begin
              alu_op = sub_alu_op;
            end else begin
              alu_op = add_alu_op;
            end
          end
          default: begin
            alu_op = alu_op_e'(funct3);
          end
        endcase
      end
      default: begin
        alu_op = add_alu_op;
      end
    endcase
  end

endmodule

// File: src/alu_rs.sv
`timescale 1ns/1ps

module alu_rs (
  input  logic                                       clk,
  input  logic                                       rst_n,
  input  logic                                       flush,
  input  logic                                       issue,
  input  ooo_pkg::issue_pkt_t                        issue_pkt,
  input  ooo_pkg::cdb_pkt_t [ooo_pkg::CDB_LANES-1:0] cdb,
  output logic                                       alu_rs_full,
  output ooo_pkg::cdb_pkt_t                          cdb_out
);
  import ooo_pkg::*;

  // resolved operand held in an entry
  typedef struct packed {
    logic     ready;
    rob_tag_t rob;
    word_t    v;
  } opnd_t;

  typedef struct packed {
    opcode_t  opcode;
    funct3_t  funct3;
    funct7_t  funct7;
    rob_tag_t target_rob;
    opnd_t    rs1;
    opnd_t    rs2;
  } entry_t;

  entry_t                entries [RS_ENTRIES];
  logic [RS_ENTRIES-1:0] busy;
  entry_t                new_entry;

  logic                  free_found;
  rs_idx_t               free_idx;
  logic                  do_issue;

  logic [RS_ENTRIES-1:0] ready_vec;
  rs_idx_t               rr_ptr;
  logic                  pick_found;
  rs_idx_t               pick_idx;

  // entry on the cdb this cycle and freed at the next edge
  logic                  sel_valid;
  rs_idx_t               sel_idx;
  entry_t                sel_entry;

  logic                  use_cmp;
  alu_op_e               exe_alu_op;
  cmp_op_e               exe_cmp_op;
  word_t                 alu_f;
  logic                  cmp_lt;

  // wake a waiting operand from any valid lane
  function automatic opnd_t snoop(input opnd_t o, input cdb_pkt_t [CDB_LANES-1:0] lanes);
    opnd_t r;
    r = o;
    for (int j = 0; j < CDB_LANES; j++) begin
      if (!r.ready && lanes[j].valid && lanes[j].rob == o.rob) begin
        r.ready = 1'b1;
        r.v     = lanes[j].value;
      end
    end
    return r;
  endfunction

  // regfile first, then rob, then wait on the tag
  function automatic opnd_t capture(input operand_src_t src,
                                    input cdb_pkt_t [CDB_LANES-1:0] lanes);
    opnd_t o;
    o.ready = 1'b0;
    o.rob   = src.rob;
    o.v     = '0;
    if (src.regfile_ready) begin
      o.ready = 1'b1;
      o.v     = src.regfile_v;
    end else if (src.rob_ready) begin
      o.ready = 1'b1;
      o.v     = src.rob_v;
    end else begin
      // a result broadcast in the issue cycle is not lost
      o = snoop(o, lanes);
    end
    return o;
  endfunction

  function automatic opnd_t const_opnd(input word_t v);
    opnd_t o;
    o.ready = 1'b1;
    o.rob   = '0;
    o.v     = v;
    return o;
  endfunction

  // lowest free entry
  always_comb begin
    free_found = 1'b0;
    free_idx   = '0;
    for (int i = RS_ENTRIES - 1; i >= 0; i--) begin
      if (!busy[i]) begin
        free_found = 1'b1;
        free_idx   = rs_idx_t'(i);
      end
    end
  end

  assign alu_rs_full = !free_found;
  assign do_issue    = issue && !alu_rs_full;

  always_comb begin
    new_entry.opcode     = issue_pkt.opcode;
    new_entry.funct3     = issue_pkt.funct3;
    new_entry.funct7     = issue_pkt.funct7;
    new_entry.target_rob = issue_pkt.target_rob;
    new_entry.rs1        = capture(issue_pkt.rs1, cdb);
    new_entry.rs2        = capture(issue_pkt.rs2, cdb);
    case (issue_pkt.opcode)
      lui_opcode: begin
        new_entry.rs1 = const_opnd('0);
        new_entry.rs2 = const_opnd(issue_pkt.imm);
      end
      auipc_opcode: begin
        new_entry.rs1 = const_opnd(issue_pkt.pc);
        new_entry.rs2 = const_opnd(issue_pkt.imm);
      end
      imm_opcode: begin
        new_entry.rs2 = const_opnd(issue_pkt.imm);
      end
      default: begin
      end
    endcase
  end

  // entry payload
  always_ff @(posedge clk) begin
    for (int i = 0; i < RS_ENTRIES; i++) begin
      if (busy[i]) begin
        entries[i].rs1 <= snoop(entries[i].rs1, cdb);
        entries[i].rs2 <= snoop(entries[i].rs2, cdb);
      end
    end
    if (do_issue) begin
      entries[free_idx] <= new_entry;
    end
  end

  // the entry on the cdb must not be picked twice
  always_comb begin
    for (int i = 0; i < RS_ENTRIES; i++) begin
      ready_vec[i] = busy[i] && entries[i].rs1.ready && entries[i].rs2.ready &&
                     !(sel_valid && sel_idx == rs_idx_t'(i));
    end
  end

  // round robin scan starting at rr_ptr
  always_comb begin
    rs_idx_t cand;
    pick_found = 1'b0;
    pick_idx   = '0;
    for (int k = RS_ENTRIES - 1; k >= 0; k--) begin
      cand = rs_idx_t'(rr_ptr + rs_idx_t'(k));
      if (ready_vec[cand]) begin
        pick_found = 1'b1;
        pick_idx   = cand;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      busy      <= '0;
      sel_valid <= 1'b0;
      sel_idx   <= '0;
      rr_ptr    <= '0;
    end else begin
      if (sel_valid) begin
        busy[sel_idx] <= 1'b0;
        rr_ptr        <= rs_idx_t'(sel_idx + 1'b1);
      end
      if (do_issue) begin
        busy[free_idx] <= 1'b1;
      end
      sel_valid <= pick_found;
      sel_idx   <= pick_idx;
    end
  end

  assign sel_entry = entries[sel_idx];

  alu_op_decode alu_op_decode_inst (
    .opcode  (sel_entry.opcode),
    .funct3  (sel_entry.funct3),
    .funct7  (sel_entry.funct7),
    .use_cmp (use_cmp),
    .alu_op  (exe_alu_op),
    .cmp_op  (exe_cmp_op)
  );

  alu alu_inst (
    .alu_op (exe_alu_op),
    .a      (sel_entry.rs1.v),
    .b      (sel_entry.rs2.v),
    .f      (alu_f)
  );

  cmp cmp_inst (
    .cmp_op (exe_cmp_op),
    .a      (sel_entry.rs1.v),
    .b      (sel_entry.rs2.v),
    .lt     (cmp_lt)
  );

  // result goes out in the select cycle
  always_comb begin
    cdb_out.valid = sel_valid;
    cdb_out.rob   = sel_entry.target_rob;
    cdb_out.value = use_cmp ? word_t'(cmp_lt) : alu_f;
  end

endmodule

// File: src/cmp.sv
`timescale 1ns/1ps

module cmp (
  input  ooo_pkg::cmp_op_e cmp_op,
  input  ooo_pkg::word_t   a,
  input  ooo_pkg::word_t   b,
  output logic             lt
);
  import ooo_pkg::*;

  always_comb begin
    case (cmp_op)
      // slt
      blt_cmp_op: begin
        lt = $signed(a) < $signed(b);
      end
      // sltu
      bltu_cmp_op: begin
        lt = a < b;
      end
      default: begin
        lt = 1'b0;
      end
    endcase
  end

endmodule

// File: src/ooo_pkg.sv
package ooo_pkg;

  // station and tag sizing
  localparam int ROB_TAG_W  = 3;
  localparam int RS_IDX_W   = 3;
  localparam int RS_ENTRIES = 2 ** RS_IDX_W;
  // lane 0 carries this unit's own result
  localparam int CDB_LANES  = 3;

  typedef logic [31:0]          word_t;
  typedef logic [ROB_TAG_W-1:0] rob_tag_t;
  typedef logic [RS_IDX_W-1:0]  rs_idx_t;
  typedef logic [6:0]           opcode_t;
  typedef logic [2:0]           funct3_t;
  typedef logic [6:0]           funct7_t;

  // rv32i opcodes handled by this unit
  localparam opcode_t lui_opcode   = 7'b0110111;
  localparam opcode_t auipc_opcode = 7'b0010111;
  localparam opcode_t imm_opcode   = 7'b0010011;
  localparam opcode_t reg_opcode   = 7'b0110011;

  localparam funct3_t add_funct3  = 3'b000;
  localparam funct3_t slt_funct3  = 3'b010;
  localparam funct3_t sltu_funct3 = 3'b011;
  localparam funct3_t sr_funct3   = 3'b101;

  // add, sll, xor, srl, or, and share their funct3 code
  typedef enum logic [2:0] {
    add_alu_op = 3'b000,
    sll_alu_op = 3'b001,
    sra_alu_op = 3'b010,
    sub_alu_op = 3'b011,
    xor_alu_op = 3'b100,
    srl_alu_op = 3'b101,
    or_alu_op  = 3'b110,
    and_alu_op = 3'b111
  } alu_op_e;

  typedef enum logic [2:0] {
    blt_cmp_op  = 3'b100,
    bltu_cmp_op = 3'b110
  } cmp_op_e;

  // one register operand as seen at issue
  typedef struct packed {
    logic     regfile_ready;
    word_t    regfile_v;
    rob_tag_t rob;
    logic     rob_ready;
    word_t    rob_v;
  } operand_src_t;

  typedef struct packed {
    opcode_t      opcode;
    funct3_t      funct3;
    funct7_t      funct7;
    word_t        imm;
    word_t        pc;
    rob_tag_t     target_rob;
    operand_src_t rs1;
    operand_src_t rs2;
  } issue_pkt_t;

  typedef struct packed {
    logic     valid;
    rob_tag_t rob;
    word_t    value;
  } cdb_pkt_t;

endpackage
